// ==== Makefile ====
# Verilator build and run of the flock testbench

SRCS := $(wildcard design/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_flock
	obj_dir/Vtb_flock | tee sim.log
	grep -q "Done: no errors" sim.log

# rebuilt only when a source or the file list changes
obj_dir/Vtb_flock: sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_flock -f sim.f -o Vtb_flock

clean:
	rm -rf obj_dir sim.log

// ==== design/boid_memory.sv ====
`timescale 1ns/100ps

module boid_memory #(
  parameter int NUM_BOIDS = 24
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic [$clog2(NUM_BOIDS)-1:0] own_addr,
  input  logic [$clog2(NUM_BOIDS)-1:0] scan_addr,
  input  logic [$clog2(NUM_BOIDS)-1:0] wr_addr,
  input  logic                         wr,
  input  boids_pkg::boid_t             wr_boid,
  input  logic                         swap,
  input  logic                         host_wr,
  output boids_pkg::boid_t             own_boid,
  output boids_pkg::boid_t             scan_boid
);
  import boids_pkg::*;

  // two banks, one holds the current frame, the other collects the next
  boid_t mem [2][NUM_BOIDS];

  // bank that reads and host loads use
  logic sel;
  // bank picked for this cycle's write
  logic wr_bank;

  // host loads go to the current bank, frame updates to the other one
  assign wr_bank = host_wr ? sel : ~sel;

  // bank select flips once at the end of every frame
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      sel <= 1'b0;
    end else if (swap) begin
      sel <= ~sel;
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr) begin
      mem[wr_bank][wr_addr] <= wr_boid;
    end
  end

  // registered reads, both from the current bank
  // own port also serves host reads while idle
  always_ff @(posedge clk_in) begin
    own_boid  <= mem[sel][own_addr];
    scan_boid <= mem[sel][scan_addr];
  end

endmodule

// ==== design/boids.sv ====
`timescale 1ns/100ps

module boids #(
  parameter int NUM_BOIDS = 24
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         start,
  input  logic                         load,
  input  logic                         read,
  input  logic [$clog2(NUM_BOIDS)-1:0] load_id,
  input  logic [$clog2(NUM_BOIDS)-1:0] read_id,
  input  boids_pkg::boid_t             load_boid,
  input  boids_pkg::boid_t             own_boid,
  input  boids_pkg::boid_t             scan_boid,
  input  logic                         data_ready,
  input  boids_pkg::boid_t             next_boid,
  output logic                         busy,
  output logic                         done,
  output logic                         read_valid,
  output logic                         new_data,
  output logic                         clear,
  output logic                         sample,
  output logic                         self,
  output logic                         wr,
  output logic                         host_wr,
  output logic                         swap,
  output logic [$clog2(NUM_BOIDS)-1:0] own_addr,
  output logic [$clog2(NUM_BOIDS)-1:0] scan_addr,
  output logic [$clog2(NUM_BOIDS)-1:0] wr_addr,
  output boids_pkg::boid_t             wr_boid,
  output boids_pkg::pos_t              pos_a,
  output boids_pkg::pos_t              pos_b,
  output boids_pkg::boid_t             nbr_boid
);
  import boids_pkg::*;

  localparam int IDX_W = $clog2(NUM_BOIDS);
  localparam logic [IDX_W-1:0] LAST_ID = IDX_W'(NUM_BOIDS - 1);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    SCAN,
    DRAIN,
    UPDATE,
    SWAP
  } state_t;

  state_t           state;
  logic             idle;
  // boid being updated and boid being compared against it
  logic [IDX_W-1:0] boid_id;
  logic [IDX_W-1:0] scan_id;
  // three cycles to empty the read and distance pipelines
  logic [1:0]       drain_cnt;
  // a scan read went out last cycle
  logic             scan_rd_q;
  // scan index, follows the read data and then the distance unit
  logic [IDX_W-1:0] scan_idx_q;
  logic [IDX_W-1:0] idx_d1;
  logic [IDX_W-1:0] idx_d2;
  // scanned boid, delayed to line up with data_ready
  boid_t            nbr_d1;
  boid_t            nbr_d2;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= IDLE;
      boid_id    <= '0;
      scan_id    <= '0;
      drain_cnt  <= '0;
      scan_rd_q  <= 1'b0;
      read_valid <= 1'b0;
    end else begin
      scan_rd_q  <= (state == SCAN);
      // host reads only answered while idle
      read_valid <= read && idle;
      case (state)
        IDLE: begin
          if (start) begin
            boid_id <= '0;
            state   <= FETCH;
          end
        end
        FETCH: begin
          // own read goes out this cycle
          scan_id <= '0;
          state   <= SCAN;
        end
        SCAN: begin
          if (scan_id == LAST_ID) begin
            drain_cnt <= '0;
            state     <= DRAIN;
          end else begin
            scan_id <= scan_id + 1'b1;
          end
        end
        DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'd2) begin
            state <= UPDATE;
          end
        end
        UPDATE: begin
          // next_boid goes to the other bank this cycle
          if (boid_id == LAST_ID) begin
            state <= SWAP;
          end else begin
            boid_id <= boid_id + 1'b1;
            state   <= FETCH;
          end
        end
        SWAP: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // alignment pipeline for the scanned boid and its index
  always_ff @(posedge clk_in) begin
    scan_idx_q <= scan_id;
    idx_d1     <= scan_idx_q;
    idx_d2     <= idx_d1;
    nbr_d1     <= scan_boid;
    nbr_d2     <= nbr_d1;
  end

  assign idle = (state == IDLE);
  assign busy = !idle;
  assign done = (state == SWAP);
  assign swap = (state == SWAP);

  // memory addressing, host read shares the own port while idle
  assign own_addr  = idle ? read_id : boid_id;
  assign scan_addr = scan_id;

  // write port, host load while idle, new state in UPDATE
  assign wr      = (idle && load) || (state == UPDATE);
  assign host_wr = idle;
  assign wr_addr = idle ? load_id : boid_id;
  assign wr_boid = idle ? load_boid : next_boid;

  // scan data lands one cycle after the read, straight into the distance unit
  assign new_data = scan_rd_q;
  assign pos_a    = own_boid.pos;
  assign pos_b    = scan_boid.pos;

  // own_boid is valid on the first scan cycle, rules capture it there
  assign clear    = (state == SCAN) && (scan_id == '0);
  assign sample   = data_ready;
  assign nbr_boid = nbr_d2;
  assign self     = (idx_d2 == boid_id);

endmodule

// ==== design/boids_pkg.sv ====
package boids_pkg;

  // position on one axis, wraps modulo 256
  typedef logic [7:0] coord_t;

  // velocity on one axis, two's complement
  typedef logic signed [7:0] speed_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } pos_t;

  typedef struct packed {
    speed_t x;
    speed_t y;
    speed_t z;
  } vel_t;

  // one memory word, also the host load and read word
  typedef struct packed {
    pos_t pos;
    vel_t vel;
  } boid_t;

  // manhattan distance, 3 x 255 fits in 10 bits
  typedef logic [9:0] dist_t;

  // cohesion sum is divided by 16
  localparam int COH_SHIFT = 4;

  // alignment sum is divided by 8
  localparam int ALIGN_SHIFT = 3;

  // separation sum is divided by 4
  localparam int SEP_SHIFT = 2;

  // per axis speed limit, both directions
  localparam int MAX_SPEED = 15;

  // rule accumulator width, signed
  localparam int ACC_W = 16;

endpackage

// ==== design/distance_3d.sv ====
`timescale 1ns/100ps

module distance_3d #(
  parameter int MAX_DISTANCE = 32
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             new_data,
  input  boids_pkg::pos_t  pos_a,
  input  boids_pkg::pos_t  pos_b,
  output logic             data_ready,
  output boids_pkg::dist_t distance,
  output logic             exceeded
);
  import boids_pkg::*;

  // stage one results, one absolute difference per axis
  coord_t dx_q;
  coord_t dy_q;
  coord_t dz_q;
  logic   valid_q;
  // unsaturated sum of stage one
  dist_t  sum;

  // |a - b| without going through a signed value
  function automatic coord_t abs_diff(input coord_t a, input coord_t b);
    return (a > b) ? a - b : b - a;
  endfunction

  // valid bit follows the data through both stages
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q    <= 1'b0;
      data_ready <= 1'b0;
    end else begin
      valid_q    <= new_data;
      data_ready <= valid_q;
    end
  end

  // stage one, plain distance on each axis, no wrap around
  always_ff @(posedge clk_in) begin
    dx_q <= abs_diff(pos_a.x, pos_b.x);
    dy_q <= abs_diff(pos_a.y, pos_b.y);
    dz_q <= abs_diff(pos_a.z, pos_b.z);
  end

  assign sum = dist_t'(dx_q) + dist_t'(dy_q) + dist_t'(dz_q);

  // stage two, saturate at the neighbour radius
  always_ff @(posedge clk_in) begin
    exceeded <= (sum >= MAX_DISTANCE);
    distance <= (sum >= MAX_DISTANCE) ? dist_t'(MAX_DISTANCE) : sum;
  end

endmodule

// ==== design/flock_rules.sv ====
`timescale 1ns/100ps

module flock_rules #(
  parameter int SEP_DISTANCE = 8
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             clear,
  input  logic             sample,
  input  logic             self,
  input  boids_pkg::boid_t own_boid,
  input  boids_pkg::boid_t nbr_boid,
  input  boids_pkg::dist_t distance,
  input  logic             exceeded,
  output boids_pkg::boid_t next_boid
);
  import boids_pkg::*;

  typedef logic signed [ACC_W-1:0] acc_t;
  // room for the speed plus three shifted sums
  typedef logic signed [ACC_W+1:0] sum_t;

  // boid being updated, captured on clear
  boid_t  own_q;
  // per axis accumulators, index 0 is x
  acc_t   coh_acc [3];
  acc_t   ali_acc [3];
  acc_t   sep_acc [3];
  // struct fields unpacked by axis
  coord_t own_p [3];
  coord_t nbr_p [3];
  speed_t own_v [3];
  speed_t nbr_v [3];
  speed_t new_v [3];
  coord_t new_p [3];
  logic   take;
  logic   near;

  // signed 9-bit position difference a - b
  function automatic acc_t coord_diff(input coord_t a, input coord_t b);
    logic signed [8:0] d;
    d = $signed({1'b0, a}) - $signed({1'b0, b});
    return acc_t'(d);
  endfunction

  function automatic acc_t speed_diff(input speed_t a, input speed_t b);
    return acc_t'(a) - acc_t'(b);
  endfunction

  // apply the three rules to one axis, then clamp
  function automatic speed_t new_speed(input speed_t v, input acc_t coh, input acc_t ali,
                                       input acc_t sep);
    sum_t total;
    total = sum_t'(v) + sum_t'(coh >>> COH_SHIFT) + sum_t'(ali >>> ALIGN_SHIFT)
          + sum_t'(sep >>> SEP_SHIFT);
    if (total > MAX_SPEED) begin
      return speed_t'(MAX_SPEED);
    end else if (total < -MAX_SPEED) begin
      return speed_t'(-MAX_SPEED);
    end
    return speed_t'(total);
  endfunction

  assign own_p = '{own_q.pos.x, own_q.pos.y, own_q.pos.z};
  assign own_v = '{own_q.vel.x, own_q.vel.y, own_q.vel.z};
  assign nbr_p = '{nbr_boid.pos.x, nbr_boid.pos.y, nbr_boid.pos.z};
  assign nbr_v = '{nbr_boid.vel.x, nbr_boid.vel.y, nbr_boid.vel.z};

  // a real neighbour, not the boid itself and inside the radius
  assign take = sample && !self && !exceeded;
  assign near = (distance < SEP_DISTANCE);

  always_ff @(posedge clk_in) begin
    if (clear) begin
      own_q <= own_boid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in || clear) begin
      for (int a = 0; a < 3; a++) begin
        coh_acc[a] <= '0;
        ali_acc[a] <= '0;
        sep_acc[a] <= '0;
      end
    end else if (take) begin
      for (int a = 0; a < 3; a++) begin
        // pull toward the neighbour
        coh_acc[a] <= coh_acc[a] + coord_diff(nbr_p[a], own_p[a]);
        // match its heading
        ali_acc[a] <= ali_acc[a] + speed_diff(nbr_v[a], own_v[a]);
        // push away only when crowded
        if (near) begin
          sep_acc[a] <= sep_acc[a] + coord_diff(own_p[a], nbr_p[a]);
        end
      end
    end
  end

  // position moves by the new velocity, 8-bit add wraps modulo 256
  always_comb begin
    for (int a = 0; a < 3; a++) begin
      new_v[a] = new_speed(own_v[a], coh_acc[a], ali_acc[a], sep_acc[a]);
      new_p[a] = own_p[a] + coord_t'(new_v[a]);
    end
  end

  assign next_boid.pos = '{x: new_p[0], y: new_p[1], z: new_p[2]};
  assign next_boid.vel = '{x: new_v[0], y: new_v[1], z: new_v[2]};

endmodule

// ==== design/flock_top.sv ====
`timescale 1ns/100ps

module flock_top #(
  parameter int NUM_BOIDS    = 24,
  parameter int MAX_DISTANCE = 32,
  parameter int SEP_DISTANCE = 8
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         load,
  input  logic                         start,
  input  logic                         read,
  input  logic [$clog2(NUM_BOIDS)-1:0] load_id,
  input  logic [$clog2(NUM_BOIDS)-1:0] read_id,
  input  boids_pkg::boid_t             load_boid,
  output logic                         busy,
  output logic                         done,
  output logic                         read_valid,
  output boids_pkg::boid_t             read_boid
);
  import boids_pkg::*;

  localparam int IDX_W = $clog2(NUM_BOIDS);

  // memory side
  logic [IDX_W-1:0] own_addr;
  logic [IDX_W-1:0] scan_addr;
  logic [IDX_W-1:0] wr_addr;
  logic             wr;
  logic             host_wr;
  logic             swap;
  boid_t            wr_boid;
  boid_t            own_boid;
  boid_t            scan_boid;
  // distance unit side
  logic             new_data;
  pos_t             pos_a;
  pos_t             pos_b;
  logic             data_ready;
  dist_t            distance;
  logic             exceeded;
  // rules side
  logic             clear;
  logic             sample;
  logic             self;
  boid_t            nbr_boid;
  boid_t            next_boid;

  boids #(
    .NUM_BOIDS(NUM_BOIDS)
  ) boids_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start(start),
    .load(load),
    .read(read),
    .load_id(load_id),
    .read_id(read_id),
    .load_boid(load_boid),
    .own_boid(own_boid),
    .scan_boid(scan_boid),
    .data_ready(data_ready),
    .next_boid(next_boid),
    .busy(busy),
    .done(done),
    .read_valid(read_valid),
    .new_data(new_data),
    .clear(clear),
    .sample(sample),
    .self(self),
    .wr(wr),
    .host_wr(host_wr),
    .swap(swap),
    .own_addr(own_addr),
    .scan_addr(scan_addr),
    .wr_addr(wr_addr),
    .wr_boid(wr_boid),
    .pos_a(pos_a),
    .pos_b(pos_b),
    .nbr_boid(nbr_boid)
  );

  boid_memory #(
    .NUM_BOIDS(NUM_BOIDS)
  ) boid_memory_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .own_addr(own_addr),
    .scan_addr(scan_addr),
    .wr_addr(wr_addr),
    .wr(wr),
    .wr_boid(wr_boid),
    .swap(swap),
    .host_wr(host_wr),
    .own_boid(own_boid),
    .scan_boid(scan_boid)
  );

  distance_3d #(
    .MAX_DISTANCE(MAX_DISTANCE)
  ) distance_3d_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .new_data(new_data),
    .pos_a(pos_a),
    .pos_b(pos_b),
    .data_ready(data_ready),
    .distance(distance),
    .exceeded(exceeded)
  );

  flock_rules #(
    .SEP_DISTANCE(SEP_DISTANCE)
  ) flock_rules_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .clear(clear),
    .sample(sample),
    .self(self),
    .own_boid(own_boid),
    .nbr_boid(nbr_boid),
    .distance(distance),
    .exceeded(exceeded),
    .next_boid(next_boid)
  );

  // host read data comes out of the own read port
  assign read_boid = own_boid;

endmodule

// ==== sim.f ====
design/boids_pkg.sv
design/distance_3d.sv
design/boid_memory.sv
design/flock_rules.sv
design/boids.sv
design/flock_top.sv
test/tb_flock.sv

// ==== test/tb_flock.sv ====
`timescale 1ns/100ps

module tb_flock;
  import boids_pkg::*;

  localparam int NB = 8;
  localparam int IDX_W = $clog2(NB);
  localparam int MAX_DIST = 32;
  localparam int SEP_DIST = 8;
  // per boid FETCH, SCAN, DRAIN and UPDATE followed by one SWAP cycle
  localparam int FRAME_CYCLES = NB * (NB + 5) + 1;
  // loads, reads and idle cycles around one frame
  localparam int HOST_CYCLES = 2 * NB + 8;
  localparam int CYCLE_LIMIT = 40 * (FRAME_CYCLES + HOST_CYCLES);

  logic             clk_in;
  logic             rst_in;
  logic             load;
  logic             start;
  logic             read;
  logic [IDX_W-1:0] load_id;
  logic [IDX_W-1:0] read_id;
  boid_t            load_boid;
  logic             busy;
  logic             done;
  logic             read_valid;
  boid_t            read_boid;

  // flock as the host expects it after the last frame
  boid_t model [NB];
  int    errors;
  int    mark;
  int    tests_run;
  int    tests_failed;
  int    frames;
  int    done_count;
  int    cycles;
  int    seed;

  flock_top #(
    .NUM_BOIDS(NB)
  ) dut_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .load(load),
    .start(start),
    .read(read),
    .load_id(load_id),
    .read_id(read_id),
    .load_boid(load_boid),
    .busy(busy),
    .done(done),
    .read_valid(read_valid),
    .read_boid(read_boid)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  // watchdog and an independent count of done pulses
  always @(posedge clk_in) begin
    cycles++;
    if (done) begin
      done_count++;
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the frame never completed", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic boid_t make_boid(input int px, input int py, input int pz,
                                      input int vx, input int vy, input int vz);
    boid_t b;
    b.pos.x = coord_t'(px);
    b.pos.y = coord_t'(py);
    b.pos.z = coord_t'(pz);
    b.vel.x = speed_t'(vx);
    b.vel.y = speed_t'(vy);
    b.vel.z = speed_t'(vz);
    return b;
  endfunction

  function automatic int pos_of(input boid_t b, input int a);
    case (a)
      0: return int'(b.pos.x);
      1: return int'(b.pos.y);
      default: return int'(b.pos.z);
    endcase
  endfunction

  // sign extended
  function automatic int vel_of(input boid_t b, input int a);
    case (a)
      0: return int'(b.vel.x);
      1: return int'(b.vel.y);
      default: return int'(b.vel.z);
    endcase
  endfunction

  function automatic int manhattan(input boid_t p, input boid_t q);
    int d;
    d = 0;
    for (int a = 0; a < 3; a++) begin
      d += (pos_of(p, a) > pos_of(q, a)) ? pos_of(p, a) - pos_of(q, a)
                                         : pos_of(q, a) - pos_of(p, a);
    end
    return d;
  endfunction

  // free flight moves the position by the velocity
  function automatic boid_t drift(input boid_t b);
    return make_boid(pos_of(b, 0) + vel_of(b, 0), pos_of(b, 1) + vel_of(b, 1),
                     pos_of(b, 2) + vel_of(b, 2), vel_of(b, 0), vel_of(b, 1), vel_of(b, 2));
  endfunction

  // one frame of the flocking rules where every boid sees only the old flock
  function automatic void advance_model();
    boid_t nxt [NB];
    int    coh [3];
    int    ali [3];
    int    sep [3];
    int    nv [3];
    int    d;
    for (int i = 0; i < NB; i++) begin
      for (int a = 0; a < 3; a++) begin
        coh[a] = 0;
        ali[a] = 0;
        sep[a] = 0;
      end
      for (int j = 0; j < NB; j++) begin
        d = manhattan(model[i], model[j]);
        if (j != i && d < MAX_DIST) begin
          for (int a = 0; a < 3; a++) begin
            coh[a] += pos_of(model[j], a) - pos_of(model[i], a);
            ali[a] += vel_of(model[j], a) - vel_of(model[i], a);
            if (d < SEP_DIST) begin
              sep[a] += pos_of(model[i], a) - pos_of(model[j], a);
            end
          end
        end
      end
      for (int a = 0; a < 3; a++) begin
        nv[a] = vel_of(model[i], a) + (coh[a] >>> COH_SHIFT) + (ali[a] >>> ALIGN_SHIFT)
              + (sep[a] >>> SEP_SHIFT);
        if (nv[a] > MAX_SPEED) begin
          nv[a] = MAX_SPEED;
        end else if (nv[a] < -MAX_SPEED) begin
          nv[a] = -MAX_SPEED;
        end
      end
      // make_boid truncates so the position wraps modulo 256
      nxt[i] = make_boid(pos_of(model[i], 0) + nv[0], pos_of(model[i], 1) + nv[1],
                         pos_of(model[i], 2) + nv[2], nv[0], nv[1], nv[2]);
    end
    for (int i = 0; i < NB; i++) begin
      model[i] = nxt[i];
    end
  endfunction

  // outputs are stable 2 ns after the edge and inputs change right after sampling
  task automatic tick();
    @(posedge clk_in);
    #2;
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Fail %0t %s: got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic load_flock();
    expect_bit("busy", busy, 1'b0);
    for (int i = 0; i < NB; i++) begin
      load      = 1'b1;
      load_id   = IDX_W'(i);
      load_boid = model[i];
      tick();
    end
    load = 1'b0;
  endtask

  // back to back reads that are each answered on the following cycle
  task automatic read_flock();
    for (int i = 0; i < NB; i++) begin
      read    = 1'b1;
      read_id = IDX_W'(i);
      tick();
      expect_bit("read_valid", read_valid, 1'b1);
      assert (read_boid == model[i]) else begin
        $display("Fail %0t read_boid[%0d]: got %h expected %h", $time, i, read_boid, model[i]);
        errors++;
      end
    end
    read = 1'b0;
    tick();
    expect_bit("read_valid", read_valid, 1'b0);
  endtask

  // noisy throws loads, starts and reads at the DUT while it is busy
  task automatic run_frame(input bit noisy);
    int          r;
    logic [47:0] noise;
    expect_bit("busy", busy, 1'b0);
    start = 1'b1;
    tick();
    start = 1'b0;
    expect_bit("busy", busy, 1'b1);
    frames++;
    while (!done) begin
      if (noisy) begin
        r         = $random(seed);
        noise     = {$random(seed), r[15:0]};
        load      = r[0];
        start     = r[1];
        read      = r[2];
        load_id   = IDX_W'(r >>> 4);
        read_id   = IDX_W'(r >>> 8);
        load_boid = noise;
      end
      tick();
      expect_bit("busy", busy, 1'b1);
      expect_bit("read_valid", read_valid, 1'b0);
    end
    load  = 1'b0;
    start = 1'b0;
    read  = 1'b0;
    // done lasts one cycle and does not come back
    repeat (3) begin
      tick();
      expect_bit("done", done, 1'b0);
      expect_bit("busy", busy, 1'b0);
    end
  endtask

  // boids packed in a 16 cube so some are crowded and some out of range
  task automatic random_flock();
    for (int i = 0; i < NB; i++) begin
      model[i] = make_boid(96 + ($random(seed) & 15), 96 + ($random(seed) & 15),
                           96 + ($random(seed) & 15), ($random(seed) & 7) - 4,
                           ($random(seed) & 7) - 4, ($random(seed) & 7) - 4);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == mark) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - mark);
    end
    mark = errors;
  endtask

  initial begin
    seed         = 32'h4b59b513;
    errors       = 0;
    mark         = 0;
    tests_run    = 0;
    tests_failed = 0;
    frames       = 0;
    done_count   = 0;
    cycles       = 0;
    rst_in       = 1'b1;
    load         = 1'b0;
    start        = 1'b0;
    read         = 1'b0;
    load_id      = '0;
    read_id      = '0;
    load_boid    = '0;
    repeat (2) @(posedge clk_in);
    #2;
    rst_in = 1'b0;

    // reset state and then a load read back untouched
    expect_bit("busy", busy, 1'b0);
    expect_bit("done", done, 1'b0);
    expect_bit("read_valid", read_valid, 1'b0);
    for (int i = 0; i < NB; i++) begin
      model[i] = make_boid(i * 17 + 3, 255 - i * 9, i * 31, i - 4, 2 * i - 7, -i);
    end
    load_flock();
    read_flock();
    finish_test("load and read");

    // exactly 32 apart on x so nobody counts as a neighbour
    for (int i = 0; i < NB; i++) begin
      model[i] = make_boid(i * 32, 16, 200, i - 4, 3, -2);
    end
    load_flock();
    run_frame(1'b0);
    for (int i = 0; i < NB; i++) begin
      model[i] = drift(model[i]);
    end
    read_flock();
    finish_test("isolated flock");

    // crowded pair, cohesion pair with equal speeds, alignment pair 8 apart, two loners
    model[0] = make_boid(100, 100, 100, 3, -2, 1);
    model[1] = make_boid(102, 101, 101, -1, 2, 0);
    model[2] = make_boid(30, 30, 30, 2, 2, 2);
    model[3] = make_boid(50, 30, 30, 2, 2, 2);
    model[4] = make_boid(200, 40, 40, -7, 0, 3);
    model[5] = make_boid(205, 43, 40, 7, 0, -3);
    model[6] = make_boid(10, 200, 200, 1, 1, 1);
    model[7] = make_boid(120, 220, 220, -1, -1, -1);
    load_flock();
    run_frame(1'b0);
    advance_model();
    read_flock();
    finish_test("rule pairs");

    // speeds far past the limit and positions at the edges of the grid
    model[0] = make_boid(250, 3, 128, 100, -100, 0);
    model[1] = make_boid(5, 250, 60, 120, 0, -128);
    model[2] = make_boid(7, 252, 61, -120, 5, 127);
    for (int i = 3; i < NB; i++) begin
      model[i] = make_boid(40 + (i - 3) * 40, 128, 220, 0, 0, 0);
    end
    load_flock();
    run_frame(1'b0);
    advance_model();
    read_flock();
    finish_test("clamp and wrap");

    // frames chained without reloading so state comes only from the last frame
    random_flock();
    load_flock();
    for (int f = 0; f < 10; f++) begin
      run_frame(1'b0);
      advance_model();
      read_flock();
    end
    finish_test("ten random frames");

    random_flock();
    load_flock();
    run_frame(1'b1);
    advance_model();
    read_flock();
    finish_test("host traffic while busy");

    assert (done_count == frames) else begin
      $display("done pulsed %0d times over %0d frames", done_count, frames);
      errors++;
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
